//--- project.f
source/tcb_pkg.sv
source/tcb_if.sv
source/tcb_converter.sv
source/tcb_misalign_guard.sv
source/tcb_mem.sv
source/tcb_top.sv
verif/tcb_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the TCB testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tcb_tb -o tcb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tcb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- source/tcb_converter.sv
////////////////////////////////////////////////////////////
// TCB reference to memory form converter
// aligns the address, builds byte enables, steers write
// data into lanes and gathers read data back
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tcb_converter (
  input  logic clk,
  input  logic arst_n,
  // reference form, from the manager
  tcb_if.sub   sub,
  // memory form, toward the memory
  tcb_if.man   man,
  // misaligned request
  output logic mal
);
  import tcb_pkg::*;

  // byte count for a size code, zero for the unused code
  function automatic logic [2:0] siz_bytes(input tcb_siz_t siz);
    case (siz)
      TCB_SIZ_BYTE: return 3'd1;
      TCB_SIZ_HALF: return 3'd2;
      TCB_SIZ_WORD: return 3'd4;
      default:      return 3'd0;
    endcase
  endfunction

  logic [TCB_BEN-1:0][7:0] sub_wdt, sub_rdt;
  logic [TCB_BEN-1:0][7:0] man_wdt, man_rdt;
  logic [TCB_BEN-1:0][1:0] req_off, req_sel;
  logic [TCB_BEN-1:0][1:0] rsp_pos, rsp_lane;
  tcb_ben_t                req_ben;
  logic [2:0]              req_num, rsp_num;

  // request fields kept for the response cycle
  logic [1:0] rsp_adr;
  tcb_siz_t   rsp_siz;
  logic       rsp_ndn;

  ////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////

  // same decode for reads and writes
  always_comb begin
    case (sub.siz)
      TCB_SIZ_BYTE: mal = 1'b0;
      TCB_SIZ_HALF: mal = sub.adr[0];
      TCB_SIZ_WORD: mal = |sub.adr[1:0];
      default:      mal = 1'b0;
    endcase
  end

  assign req_num = siz_bytes(sub.siz);
  assign sub_wdt = sub.wdt;

  // lane i holds sub byte req_off[i] in little endian,
  // mirrored within the access size in big endian
  always_comb begin
    for (int i = 0; i < TCB_BEN; i++) begin
      req_off[i] = 2'(i) - sub.adr[1:0];
      req_ben[i] = {1'b0, req_off[i]} < req_num;
      req_sel[i] = sub.ndn ? 2'(req_num) - 2'd1 - req_off[i] : req_off[i];
      man_wdt[i] = req_ben[i] ? sub_wdt[req_sel[i]] : 8'h00;
    end
  end

  assign man.vld = sub.vld;
  assign man.wen = sub.wen;
  assign man.ndn = sub.ndn;
  assign man.siz = sub.siz;
  // word aligned address on the memory side
  assign man.adr = {sub.adr[31:2], 2'b00};
  assign man.ben = req_ben;
  assign man.wdt = man_wdt;

  ////////////////////////////////////////////////////////////
  // response path
  ////////////////////////////////////////////////////////////

  // capture on each transfer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_adr <= 2'b00;
      rsp_siz <= TCB_SIZ_BYTE;
      rsp_ndn <= 1'b0;
    end else if (sub.vld && man.rdy) begin
      rsp_adr <= sub.adr[1:0];
      rsp_siz <= sub.siz;
      rsp_ndn <= sub.ndn;
    end
  end

  assign rsp_num = siz_bytes(rsp_siz);
  assign man_rdt = man.rdt;

  // inverse of the write mapping, upper bytes zero
  always_comb begin
    for (int k = 0; k < TCB_BEN; k++) begin
      rsp_pos[k]  = rsp_ndn ? 2'(rsp_num) - 2'd1 - 2'(k) : 2'(k);
      rsp_lane[k] = rsp_adr + rsp_pos[k];
      sub_rdt[k]  = (3'(k) < rsp_num) ? man_rdt[rsp_lane[k]] : 8'h00;
    end
  end

  assign sub.rdt = sub_rdt;
  assign sub.sts = man.sts;
  assign sub.rdy = man.rdy;

endmodule : tcb_converter

`default_nettype wire

//--- source/tcb_if.sv
////////////////////////////////////////////////////////////
// TCB interface
// one request/response channel with manager and
// subordinate views
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

interface tcb_if ();
  import tcb_pkg::*;

  // handshake
  logic     vld;
  logic     rdy;

  // request
  logic     wen;
  logic     ndn;
  tcb_siz_t siz;
  tcb_adr_t adr;
  // byte enables, zero in reference form
  tcb_ben_t ben;
  tcb_dat_t wdt;

  // response, valid TCB_DLY cycles after the transfer
  tcb_dat_t rdt;
  tcb_sts_t sts;

  // manager side drives the request
  modport man (
    output vld, wen, ndn, siz, adr, ben, wdt,
    input  rdy, rdt, sts
  );

  // subordinate side answers
  modport sub (
    input  vld, wen, ndn, siz, adr, ben, wdt,
    output rdy, rdt, sts
  );

endinterface : tcb_if

`default_nettype wire

//--- source/tcb_mem.sv
////////////////////////////////////////////////////////////
// TCB memory
// byte enabled synchronous RAM, read data one cycle after
// the transfer
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tcb_mem #(
  // word address width
  parameter int unsigned MEM_ADW = 8
) (
  input  logic clk,
  input  logic arst_n,
  tcb_if.sub   sub
);
  import tcb_pkg::*;

  localparam int unsigned MEM_SIZ = 2**MEM_ADW;

  // storage, one byte per lane
  logic [TCB_BEN-1:0][7:0] mem_arr [0:MEM_SIZ-1];

  logic [TCB_BEN-1:0][7:0] mem_wdt;
  logic [MEM_ADW-1:0]      mem_adr;
  logic                    mem_trn;
  logic                    rdy_q;
  tcb_dat_t                rdt_q;

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  // ready from the first clock after reset, never lowered
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdy_q <= 1'b0;
    end else begin
      rdy_q <= 1'b1;
    end
  end

  assign mem_trn = sub.vld & rdy_q;
  // word address, lane bits dropped
  assign mem_adr = sub.adr[MEM_ADW+1:2];
  assign mem_wdt = sub.wdt;

  ////////////////////////////////////////////////////////////
  // array access
  ////////////////////////////////////////////////////////////

  // write only the enabled lanes
  always_ff @(posedge clk) begin
    if (mem_trn && sub.wen) begin
      for (int i = 0; i < TCB_BEN; i++) begin
        if (sub.ben[i]) begin
          mem_arr[mem_adr][i] <= mem_wdt[i];
        end
      end
    end
  end

  // full word read, lanes sorted out by the converter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdt_q <= '0;
    end else if (mem_trn && !sub.wen) begin
      rdt_q <= mem_arr[mem_adr];
    end
  end

  assign sub.rdy = rdy_q;
  assign sub.rdt = rdt_q;
  assign sub.sts = TCB_OKAY;

endmodule : tcb_mem

`default_nettype wire

//--- source/tcb_misalign_guard.sv
////////////////////////////////////////////////////////////
// TCB misalignment guard
// blocks writes of misaligned transfers and answers them
// with error status and zero data
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tcb_misalign_guard (
  input  logic clk,
  input  logic arst_n,
  // misaligned flag from the converter
  input  logic mal,
  tcb_if.sub   sub,
  tcb_if.man   man
);
  import tcb_pkg::*;

  // error flags in flight, oldest at the top
  logic [TCB_DLY-1:0] err_dly;
  logic               err_trn;
  logic               err_rsp;

  ////////////////////////////////////////////////////////////
  // request
  ////////////////////////////////////////////////////////////

  assign man.vld = sub.vld;
  // misaligned access must leave memory untouched
  assign man.wen = sub.wen & ~mal;
  assign man.ben = mal ? '0 : sub.ben;
  assign man.ndn = sub.ndn;
  assign man.siz = sub.siz;
  assign man.adr = sub.adr;
  assign man.wdt = sub.wdt;

  ////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////

  // only an accepted misaligned transfer answers with an error
  assign err_trn = sub.vld & man.rdy & mal;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      err_dly <= '0;
    end else begin
      err_dly <= TCB_DLY'({err_dly, err_trn});
    end
  end

  assign err_rsp = err_dly[TCB_DLY-1];

  // replace the memory answer
  assign sub.rdt = err_rsp ? '0 : man.rdt;
  assign sub.sts = err_rsp ? TCB_ERROR : man.sts;
  assign sub.rdy = man.rdy;

endmodule : tcb_misalign_guard

`default_nettype wire

//--- source/tcb_pkg.sv
////////////////////////////////////////////////////////////
// TCB package
// width typedefs, size and status codes, fixed response
// delay of the tightly coupled bus
////////////////////////////////////////////////////////////

`default_nettype none

package tcb_pkg;

  ////////////////////////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////////////////////////

  // byte lanes in a data word
  localparam int unsigned TCB_BEN = 4;

  // response follows the transfer after this many cycles
  localparam int unsigned TCB_DLY = 1;

  // byte address
  typedef logic [31:0] tcb_adr_t;

  // data word, four byte lanes
  typedef logic [31:0] tcb_dat_t;

  // one enable bit per lane
  typedef logic [TCB_BEN-1:0] tcb_ben_t;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  // transfer size as log2 of the byte count
  // code 3 would be a doubleword, not on this bus
  typedef enum logic [1:0] {
    TCB_SIZ_BYTE = 2'd0,
    TCB_SIZ_HALF = 2'd1,
    TCB_SIZ_WORD = 2'd2
  } tcb_siz_t;

  // response status
  typedef enum logic {
    TCB_OKAY  = 1'b0,
    TCB_ERROR = 1'b1
  } tcb_sts_t;

endpackage : tcb_pkg

`default_nettype wire

//--- source/tcb_top.sv
////////////////////////////////////////////////////////////
// TCB subsystem top
// reference form port into converter, misalignment guard
// and byte enabled memory
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tcb_top #(
  parameter int unsigned MEM_ADW = 8
) (
  input  logic              clk,
  input  logic              arst_n,
  // request
  input  logic              vld,
  input  logic              wen,
  input  logic              ndn,
  input  tcb_pkg::tcb_siz_t siz,
  input  tcb_pkg::tcb_adr_t adr,
  input  tcb_pkg::tcb_dat_t wdt,
  // response
  output logic              rdy,
  output tcb_pkg::tcb_dat_t rdt,
  output tcb_pkg::tcb_sts_t sts,
  // misaligned request, same cycle
  output logic              mal
);

  // reference form, converter to guard, guard to memory
  tcb_if bus_ref ();
  tcb_if bus_mem ();
  tcb_if bus_grd ();

  // plain ports onto the reference bus
  assign bus_ref.vld = vld;
  assign bus_ref.wen = wen;
  assign bus_ref.ndn = ndn;
  assign bus_ref.siz = siz;
  assign bus_ref.adr = adr;
  // no byte enables in reference form
  assign bus_ref.ben = '0;
  assign bus_ref.wdt = wdt;

  assign rdy = bus_ref.rdy;
  assign rdt = bus_ref.rdt;
  assign sts = bus_ref.sts;

  tcb_converter tcb_converter_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .sub    (bus_ref),
    .man    (bus_mem),
    .mal    (mal)
  );

  tcb_misalign_guard tcb_misalign_guard_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .mal    (mal),
    .sub    (bus_mem),
    .man    (bus_grd)
  );

  tcb_mem #(
    .MEM_ADW (MEM_ADW)
  ) tcb_mem_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .sub    (bus_grd)
  );

endmodule : tcb_top

`default_nettype wire

//--- verif/tcb_tb.sv
////////////////////////////////////////////////////////////
// TCB subsystem testbench
// byte model of the memory, xorshift stimulus, response
// and misalignment checks one cycle after each transfer
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tcb_tb;
  import tcb_pkg::*;

  // transfers, reset and idle cycles, rounded up
  localparam int unsigned N_XFER = 320;
  localparam int unsigned RUN_NS = N_XFER * 10 + 2000;

  logic     clk;
  logic     arst_n;
  logic     vld, wen, ndn;
  tcb_siz_t siz;
  tcb_adr_t adr;
  tcb_dat_t wdt;
  logic     rdy, mal;
  tcb_dat_t rdt;
  tcb_sts_t sts;

  // reference bytes for the 16 words under test
  logic [7:0]  model [0:63];
  logic [31:0] rng_state;
  int          errors;
  int          checks;

  // response owed by the previous transfer
  logic     pend, pend_rd, pend_err;
  tcb_dat_t pend_rdt;
  string    pend_name;

  tcb_top #(
    .MEM_ADW (8)
  ) tcb_top_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .vld    (vld),
    .wen    (wen),
    .ndn    (ndn),
    .siz    (siz),
    .adr    (adr),
    .wdt    (wdt),
    .rdy    (rdy),
    .rdt    (rdt),
    .sts    (sts),
    .mal    (mal)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // watchdog
  initial begin
    #(RUN_NS);
    $display("timeout: run did not finish within %0d ns", RUN_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
    checks++;
    assert (act_val === exp_val) else begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp_val, act_val);
      errors++;
    end
  endtask

  // response of the transfer one cycle back
  task automatic check_rsp();
    if (pend) begin
      check_val({pend_name, " sts"}, 32'(pend_err ? TCB_ERROR : TCB_OKAY), 32'(sts));
      // write data response carries no meaning
      if (pend_rd || pend_err) begin
        check_val({pend_name, " rdt"}, pend_rdt, rdt);
      end
    end
  endtask

  // one transfer, called on a falling edge, returns on the next
  task automatic transfer(input string name, input logic w, input logic e,
                          input logic [1:0] s, input logic [5:0] a, input tcb_dat_t d);
    int         n;
    int         j;
    logic       m;
    logic [5:0] b;
    tcb_dat_t   exp_rdt;
    check_rsp();
    vld = 1'b1;
    wen = w;
    ndn = e;
    siz = tcb_siz_t'(s);
    adr = {26'd0, a};
    wdt = d;
    n = 1 << s;
    m = (s == 2'd1 && a[0]) || (s == 2'd2 && a[1:0] != 2'b00);
    exp_rdt = '0;
    // byte k of the access sits in lane adr+k, mirrored for big endian
    for (int k = 0; k < n; k++) begin
      b = {a[5:2], a[1:0] + k[1:0]};
      j = e ? n - 1 - k : k;
      if (!m && w) begin
        model[b] = d[8*j +: 8];
      end else if (!m) begin
        exp_rdt[8*j +: 8] = model[b];
      end
    end
    #1;
    check_val({name, " rdy"}, 32'd1, {31'd0, rdy});
    check_val({name, " mal"}, {31'd0, m}, {31'd0, mal});
    pend = 1'b1;
    pend_rd = !w;
    pend_err = m;
    pend_rdt = exp_rdt;
    pend_name = name;
    @(negedge clk);
  endtask

  task automatic random_xfer(input string name, input logic align);
    logic [31:0] r;
    logic [1:0]  s;
    logic [5:0]  a;
    r = next_rand();
    s = r[1:0] % 2'd3;
    a = r[7:2];
    if (align) begin
      a = a & ~((6'd1 << s) - 6'd1);
    end
    transfer(name, r[8], r[9], s, a, next_rand());
  endtask

  task automatic idle();
    check_rsp();
    pend = 1'b0;
    vld = 1'b0;
    @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    rng_state = 32'd96330;
    errors = 0;
    checks = 0;
    pend = 1'b0;
    arst_n = 1'b0;
    vld = 1'b0;
    wen = 1'b0;
    ndn = 1'b0;
    siz = TCB_SIZ_BYTE;
    adr = '0;
    wdt = '0;

    // reset state
    repeat (16) begin
      @(negedge clk);
      check_val("reset rdy", 32'd0, {31'd0, rdy});
    end
    arst_n = 1'b1;
    @(negedge clk);
    check_val("post reset rdy", 32'd1, {31'd0, rdy});
    check_val("post reset sts", 32'(TCB_OKAY), 32'(sts));
    check_val("post reset rdt", 32'd0, rdt);
    check_val("post reset mal", 32'd0, {31'd0, mal});

    // aligned words, fills every modelled byte
    for (int i = 0; i < 16; i++) begin
      transfer("word write", 1'b1, 1'b0, 2'd2, 6'(4 * i), next_rand());
    end
    repeat (16) begin
      r = next_rand();
      transfer("word read", 1'b0, 1'b0, 2'd2, {r[3:0], 2'b00}, '0);
    end

    // bytes and halfwords, both byte orders
    transfer("be half write", 1'b1, 1'b1, 2'd1, 6'h06, 32'h0000_beef);
    transfer("le word read", 1'b0, 1'b0, 2'd2, 6'h04, '0);
    transfer("le byte write", 1'b1, 1'b0, 2'd0, 6'h09, 32'h0000_005a);
    transfer("be half read", 1'b0, 1'b1, 2'd1, 6'h0a, '0);
    repeat (40) random_xfer("mixed aligned", 1'b1);
    idle();

    // misaligned requests leave memory alone
    transfer("odd half write", 1'b1, 1'b0, 2'd1, 6'h11, 32'h1234_5678);
    transfer("unaligned word write", 1'b1, 1'b1, 2'd2, 6'h12, 32'hcafe_f00d);
    transfer("unaligned word read", 1'b0, 1'b0, 2'd2, 6'h13, '0);
    transfer("after misaligned read", 1'b0, 1'b0, 2'd2, 6'h10, '0);
    idle();

    // back to back, vld never drops
    repeat (200) random_xfer("pipeline", 1'b0);
    idle();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : tcb_tb

`default_nettype wire
